// ==== logic/la_defines.svh ====
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// number of probe ports, one sample buffer each
`define LA_PORT_NUM 3

// words per sample buffer
`define LA_SAMPLE_DEPTH 2048

// global sample address carried in a read request
`define LA_ADDR_W 16

// address inside one buffer, log2 of the depth
`define LA_LADDR_W 11

// word count field of a read request
`define LA_NUM_W 10

// probe and sample word width
`define LA_SAMPLE_W 16

`endif

// ==== logic/cmd_pkg.sv ====
`include "la_defines.svh"

package cmd_pkg;

    // first word of a frame selects its kind
    localparam logic [7:0] OP_WRITE = 8'h00;
    localparam logic [7:0] OP_READ = 8'hFF;

    // write frame payload that arms the capture
    localparam logic [31:0] TRIG_WORD = 32'h0000_FFFF;

    // one received word, two ways to look at it
    // ctrl is used on the opening word, rd on each request of a read frame
    typedef union packed {
        struct packed {
            logic [7:0] opcode;
            logic [23:0] rsvd;
        } ctrl;
        struct packed {
            logic [31-`LA_NUM_W-`LA_ADDR_W:0] rsvd;
            logic [`LA_NUM_W-1:0] num;
            logic [`LA_ADDR_W-1:0] addr;
        } rd;
    } cmd_word_u;

endpackage

// ==== logic/capture_pkg.sv ====
`include "la_defines.svh"

package capture_pkg;

    // capture progress of one buffer
    // done holds until the trigger rises again
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_RUN,
        CAP_DONE
    } cap_state_e;

    // one probe sample
    typedef logic [`LA_SAMPLE_W-1:0] sample_t;

endpackage

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module cmd_decoder (
    input  logic                     rxclk,
    input  logic                     rstn,
    input  logic                     sfp_rxdatavalid,
    input  logic                     sfp_rxdatalast,
    input  logic [31:0]              sfp_rxdata,
    output logic                     trigger,
    output logic [`LA_PORT_NUM-1:0]  porten,
    output logic [`LA_LADDR_W-1:0]   addr,
    output logic [`LA_NUM_W-1:0]     num
);
    import cmd_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_READ = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_SKIP = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;
    cmd_word_u word;
    logic req;
    logic [`LA_PORT_NUM-1:0] hit;
    logic [`LA_LADDR_W-1:0] local_addr;

    assign word = sfp_rxdata;
    assign req = (state == ST_READ) && sfp_rxdatavalid;

    // frame tracking, a single-word frame never leaves idle
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (sfp_rxdatavalid && !sfp_rxdatalast) begin
                    case (word.ctrl.opcode)
                        OP_READ: next_state = ST_READ;
                        OP_WRITE: next_state = ST_WRITE;
                        default: next_state = ST_SKIP;
                    endcase
                end
            end
            default: begin
                if (sfp_rxdatavalid && sfp_rxdatalast) begin
                    next_state = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // trigger word sets, end of the write frame clears
    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            trigger <= 1'b0;
        end else if (state == ST_WRITE) begin
            if (sfp_rxdatavalid && sfp_rxdata == TRIG_WORD) begin
                trigger <= 1'b1;
            end else if (sfp_rxdatavalid && sfp_rxdatalast) begin
                trigger <= 1'b0;
            end
        end else begin
            trigger <= 1'b0;
        end
    end

    // which port window holds the global address
    always_comb begin
        hit = '0;
        local_addr = '0;
        for (int i = 0; i < `LA_PORT_NUM; i++) begin
            if (int'(word.rd.addr) >= i * `LA_SAMPLE_DEPTH &&
                int'(word.rd.addr) < (i + 1) * `LA_SAMPLE_DEPTH) begin
                hit[i] = 1'b1;
                local_addr = `LA_LADDR_W'(int'(word.rd.addr) - i * `LA_SAMPLE_DEPTH);
            end
        end
    end

    // out-of-range requests give an all-zero strobe
    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            porten <= '0;
        end else begin
            porten <= req ? hit : '0;
        end
    end

    always_ff @(posedge rxclk) begin
        if (req && |hit) begin
            addr <= local_addr;
            num <= word.rd.num;
        end
    end

endmodule

// ==== logic/sample_buffer.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module sample_buffer (
    input  logic                    rxclk,
    input  logic                    rstn,
    input  logic                    trigger,
    input  capture_pkg::sample_t    probe,
    input  logic                    rd_en,
    input  logic [`LA_LADDR_W-1:0]  rd_addr,
    output capture_pkg::sample_t    rd_data,
    output logic                    cap_done
);
    import capture_pkg::*;

    sample_t mem [`LA_SAMPLE_DEPTH];

    cap_state_e state;
    logic trig_q;
    logic trig_rise;
    logic [`LA_LADDR_W-1:0] wr_cnt;
    logic wr_en;

    assign trig_rise = trigger && !trig_q;

    // index 0 is written on the rising edge itself
    // wr_cnt wraps back to 0 as the buffer fills and rests there
    assign wr_en = (state == CAP_RUN) || trig_rise;

    assign cap_done = (state == CAP_DONE);

    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= trigger;
        end
    end

    // a trigger inside a run is ignored
    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            state <= CAP_IDLE;
            wr_cnt <= '0;
        end else begin
            case (state)
                CAP_RUN: begin
                    wr_cnt <= wr_cnt + 1'b1;
                    if (wr_cnt == `LA_LADDR_W'(`LA_SAMPLE_DEPTH - 1)) begin
                        state <= CAP_DONE;
                    end
                end
                default: begin
                    if (trig_rise) begin
                        state <= CAP_RUN;
                        wr_cnt <= `LA_LADDR_W'(1);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rxclk) begin
        if (wr_en) begin
            mem[wr_cnt] <= probe;
        end
    end

    // read side does not look at the capture state
    always_ff @(posedge rxclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/readout_sequencer.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module readout_sequencer (
    input  logic                                    rxclk,
    input  logic                                    rstn,
    input  logic [`LA_PORT_NUM-1:0]                 porten,
    input  logic [`LA_LADDR_W-1:0]                  addr,
    input  logic [`LA_NUM_W-1:0]                    num,
    input  logic [`LA_PORT_NUM*`LA_SAMPLE_W-1:0]    rd_data_all,
    output logic [`LA_PORT_NUM-1:0]                 rd_en,
    output logic [`LA_LADDR_W-1:0]                  rd_addr,
    output logic                                    tx_valid,
    output logic                                    tx_last,
    output logic [31:0]                             tx_data,
    output logic [1:0]                              tx_port
);
    import capture_pkg::*;

    logic busy;
    logic [`LA_NUM_W-1:0] remaining;
    logic [`LA_LADDR_W-1:0] rd_ptr;
    logic [1:0] req_idx;
    logic [1:0] port_sel;
    logic [1:0] port_q;
    logic [`LA_LADDR_W-1:0] tag_q;
    logic accept;
    logic issue_last;
    sample_t rd_sel;

    // one-hot strobe to port index
    always_comb begin
        req_idx = '0;
        for (int i = 0; i < `LA_PORT_NUM; i++) begin
            if (porten[i]) begin
                req_idx = 2'(i);
            end
        end
    end

    // requests arriving mid-burst are lost
    assign accept = |porten && !busy && num != '0;
    assign issue_last = busy && remaining == `LA_NUM_W'(1);

    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            remaining <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            remaining <= num;
        end else if (busy) begin
            busy <= !issue_last;
            remaining <= remaining - 1'b1;
        end
    end

    // local address wraps at the buffer depth
    always_ff @(posedge rxclk) begin
        if (accept) begin
            rd_ptr <= addr;
            port_sel <= req_idx;
        end else if (busy) begin
            if (rd_ptr == `LA_LADDR_W'(`LA_SAMPLE_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LA_PORT_NUM; i++) begin
            rd_en[i] = busy && port_sel == 2'(i);
        end
    end
    assign rd_addr = rd_ptr;

    // tag and port follow the memory latency
    always_ff @(posedge rxclk) begin
        tag_q <= rd_ptr;
        port_q <= port_sel;
    end

    always_ff @(posedge rxclk or negedge rstn) begin
        if (!rstn) begin
            tx_valid <= 1'b0;
            tx_last <= 1'b0;
        end else begin
            tx_valid <= busy;
            tx_last <= issue_last;
        end
    end

    assign rd_sel = rd_data_all[port_q*`LA_SAMPLE_W +: `LA_SAMPLE_W];
    assign tx_data = {`LA_ADDR_W'(tag_q), rd_sel};
    assign tx_port = port_q;

endmodule

// ==== logic/la_rx_top.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module la_rx_top (
    input  logic                                    rxclk,
    input  logic                                    rstn,
    input  logic                                    sfp_rxdatavalid,
    input  logic                                    sfp_rxdatalast,
    input  logic [31:0]                             sfp_rxdata,
    input  logic [`LA_PORT_NUM*`LA_SAMPLE_W-1:0]    probe,
    output logic                                    trigger,
    output logic [`LA_PORT_NUM-1:0]                 cap_done,
    output logic                                    tx_valid,
    output logic                                    tx_last,
    output logic [31:0]                             tx_data,
    output logic [1:0]                              tx_port
);
    import capture_pkg::*;

    logic [`LA_PORT_NUM-1:0] porten;
    logic [`LA_LADDR_W-1:0] addr;
    logic [`LA_NUM_W-1:0] num;
    logic [`LA_PORT_NUM-1:0] rd_en;
    logic [`LA_LADDR_W-1:0] rd_addr;
    sample_t [`LA_PORT_NUM-1:0] rd_data_all;

    cmd_decoder i_cmd_decoder (
        .rxclk           (rxclk),
        .rstn            (rstn),
        .sfp_rxdatavalid (sfp_rxdatavalid),
        .sfp_rxdatalast  (sfp_rxdatalast),
        .sfp_rxdata      (sfp_rxdata),
        .trigger         (trigger),
        .porten          (porten),
        .addr            (addr),
        .num             (num)
    );

    // one capture buffer per probe port
    for (genvar i = 0; i < `LA_PORT_NUM; i++) begin : g_buf
        sample_buffer i_sample_buffer (
            .rxclk    (rxclk),
            .rstn     (rstn),
            .trigger  (trigger),
            .probe    (probe[i*`LA_SAMPLE_W +: `LA_SAMPLE_W]),
            .rd_en    (rd_en[i]),
            .rd_addr  (rd_addr),
            .rd_data  (rd_data_all[i]),
            .cap_done (cap_done[i])
        );
    end

    readout_sequencer i_readout_sequencer (
        .rxclk       (rxclk),
        .rstn        (rstn),
        .porten      (porten),
        .addr        (addr),
        .num         (num),
        .rd_data_all (rd_data_all),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .tx_valid    (tx_valid),
        .tx_last     (tx_last),
        .tx_data     (tx_data),
        .tx_port     (tx_port)
    );

endmodule

// ==== tb/la_checker.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module la_checker (
    input  logic                                    rxclk,
    input  logic                                    rstn,
    input  logic                                    sfp_rxdatavalid,
    input  logic                                    sfp_rxdatalast,
    input  logic [31:0]                             sfp_rxdata,
    input  logic [`LA_PORT_NUM*`LA_SAMPLE_W-1:0]    probe,
    input  logic                                    trigger,
    input  logic [`LA_PORT_NUM-1:0]                 cap_done,
    input  logic                                    tx_valid,
    input  logic                                    tx_last,
    input  logic [31:0]                             tx_data,
    input  logic [1:0]                              tx_port,
    output int                                      err_count,
    output logic                                    busy
);
    import cmd_pkg::*;

    localparam int DEPTH = `LA_SAMPLE_DEPTH;
    localparam int WINDOWS = `LA_PORT_NUM * `LA_SAMPLE_DEPTH;
    localparam int F_IDLE = 0;
    localparam int F_READ = 1;
    localparam int F_WRITE = 2;
    localparam int F_SKIP = 3;

    logic [`LA_SAMPLE_W-1:0] model_mem [`LA_PORT_NUM][DEPTH];
    int frame = F_IDLE;
    logic m_trig = 1'b0;
    logic m_trig_q = 1'b0;
    // -1 before the first arming, DEPTH once full
    int cap_idx = -1;
    longint cyc = 0;
    longint busy_until = -8;
    int errors = 0;

    // expected output words, each with the cycle it is due in
    longint exp_cyc [$];
    logic [31:0] exp_data [$];
    logic [1:0] exp_port [$];
    logic exp_last [$];

    assign err_count = errors;

    task automatic drop_front();
        void'(exp_cyc.pop_front());
        void'(exp_data.pop_front());
        void'(exp_port.pop_front());
        void'(exp_last.pop_front());
    endtask

    task automatic check_outputs();
        logic due;
        due = exp_cyc.size() != 0 && exp_cyc[0] == cyc;
        if (trigger !== m_trig) begin
            $display("ERR %0t: trigger %b, expected %b", $time, trigger, m_trig);
            errors++;
        end
        if (cap_done !== {`LA_PORT_NUM{cap_idx == DEPTH}}) begin
            $display("ERR %0t: cap_done %b, expected %b on every port", $time,
                     cap_done, cap_idx == DEPTH);
            errors++;
        end
        if (tx_valid === 1'b1 && !due) begin
            $display("surplus output word 0x%08h from port %0d at time %0t, no burst was due",
                     tx_data, tx_port, $time);
            errors++;
        end else if (tx_valid !== 1'b1 && due) begin
            $display("output word 0x%08h from port %0d is missing at time %0t",
                     exp_data[0], exp_port[0], $time);
            errors++;
            drop_front();
        end else if (due) begin
            if (tx_data !== exp_data[0] || tx_port !== exp_port[0] ||
                tx_last !== exp_last[0]) begin
                $display("ERR %0t: word 0x%08h port %0d last %b, expected 0x%08h port %0d last %b",
                         $time, tx_data, tx_port, tx_last, exp_data[0], exp_port[0],
                         exp_last[0]);
                errors++;
            end
            drop_front();
        end
    endtask

    // capture starts on the rising edge of the model trigger
    task automatic step_capture();
        int p;
        if (m_trig && !m_trig_q && !(cap_idx >= 0 && cap_idx < DEPTH)) begin
            cap_idx = 0;
        end
        if (cap_idx >= 0 && cap_idx < DEPTH) begin
            for (p = 0; p < `LA_PORT_NUM; p++) begin
                model_mem[p][cap_idx] = probe[p*`LA_SAMPLE_W +: `LA_SAMPLE_W];
            end
            cap_idx++;
        end
        m_trig_q = m_trig;
    endtask

    task automatic step_frame();
        cmd_word_u w;
        int gaddr;
        int count;
        int port;
        int a;
        int i;
        w = sfp_rxdata;
        gaddr = int'(w.rd.addr);
        count = int'(w.rd.num);
        // first beat three cycles after the request, none while a burst runs
        if (sfp_rxdatavalid && frame == F_READ && gaddr < WINDOWS && count != 0 &&
            cyc + 1 > busy_until) begin
            port = gaddr / DEPTH;
            busy_until = cyc + 1 + count;
            for (i = 0; i < count; i++) begin
                a = (gaddr % DEPTH + i) % DEPTH;
                exp_cyc.push_back(cyc + 3 + i);
                exp_data.push_back({16'(a), model_mem[port][a]});
                exp_port.push_back(2'(port));
                exp_last.push_back(i == count - 1);
            end
        end
        if (frame != F_WRITE) begin
            m_trig = 1'b0;
        end else if (sfp_rxdatavalid && sfp_rxdata == TRIG_WORD) begin
            m_trig = 1'b1;
        end else if (sfp_rxdatavalid && sfp_rxdatalast) begin
            m_trig = 1'b0;
        end
        if (frame == F_IDLE && sfp_rxdatavalid && !sfp_rxdatalast) begin
            if (w.ctrl.opcode == OP_READ) begin
                frame = F_READ;
            end else if (w.ctrl.opcode == OP_WRITE) begin
                frame = F_WRITE;
            end else begin
                frame = F_SKIP;
            end
        end else if (frame != F_IDLE && sfp_rxdatavalid && sfp_rxdatalast) begin
            frame = F_IDLE;
        end
    endtask

    always @(posedge rxclk) begin
        if (!rstn) begin
            frame = F_IDLE;
            m_trig = 1'b0;
            m_trig_q = 1'b0;
            cap_idx = -1;
            cyc = 0;
            busy_until = -8;
            exp_cyc.delete();
            exp_data.delete();
            exp_port.delete();
            exp_last.delete();
        end else begin
            cyc++;
            check_outputs();
            step_capture();
            step_frame();
        end
        busy = exp_cyc.size() != 0 || (cap_idx >= 0 && cap_idx < DEPTH) ||
               (m_trig && !m_trig_q);
    end

endmodule

// ==== tb/tb_la_rx.sv ====
`timescale 1ns/10ps
`include "la_defines.svh"

module tb_la_rx;

    logic rxclk = 1'b0;
    logic rstn;
    logic sfp_rxdatavalid;
    logic sfp_rxdatalast;
    logic [31:0] sfp_rxdata;
    logic [`LA_PORT_NUM*`LA_SAMPLE_W-1:0] probe = '0;
    logic trigger;
    logic [`LA_PORT_NUM-1:0] cap_done;
    logic tx_valid;
    logic tx_last;
    logic [31:0] tx_data;
    logic [1:0] tx_port;
    int chk_errors;
    logic chk_busy;

    // one entry per vector line
    int v_test [$];
    logic v_last [$];
    logic [31:0] v_data [$];
    int v_len [$];

    logic [31:0] seed = 32'd22321;
    int beat_total = 0;
    int tb_errors = 0;
    int cur_test;
    int err_mark;
    int n_pass = 0;
    int n_fail = 0;
    bit load_done = 1'b0;

    la_rx_top i_la_rx_top (
        .rxclk           (rxclk),
        .rstn            (rstn),
        .sfp_rxdatavalid (sfp_rxdatavalid),
        .sfp_rxdatalast  (sfp_rxdatalast),
        .sfp_rxdata      (sfp_rxdata),
        .probe           (probe),
        .trigger         (trigger),
        .cap_done        (cap_done),
        .tx_valid        (tx_valid),
        .tx_last         (tx_last),
        .tx_data         (tx_data),
        .tx_port         (tx_port)
    );

    la_checker i_la_checker (
        .rxclk           (rxclk),
        .rstn            (rstn),
        .sfp_rxdatavalid (sfp_rxdatavalid),
        .sfp_rxdatalast  (sfp_rxdatalast),
        .sfp_rxdata      (sfp_rxdata),
        .probe           (probe),
        .trigger         (trigger),
        .cap_done        (cap_done),
        .tx_valid        (tx_valid),
        .tx_last         (tx_last),
        .tx_data         (tx_data),
        .tx_port         (tx_port),
        .err_count       (chk_errors),
        .busy            (chk_busy)
    );

    always #10 rxclk = ~rxclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fresh probe values every cycle
    always @(negedge rxclk) begin
        for (int p = 0; p < `LA_PORT_NUM; p++) begin
            seed = lcg_next(seed);
            probe[p*`LA_SAMPLE_W +: `LA_SAMPLE_W] = seed[31:16];
        end
    end

    always @(posedge rxclk) begin
        if (tx_valid === 1'b1) begin
            beat_total <= beat_total + 1;
        end
    end

    task automatic load_vectors();
        int fd;
        int t;
        int l;
        int n;
        logic [31:0] d;
        reg [8*128-1:0] line;
        fd = $fopen("tb/la_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open vector file tb/la_vectors.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && $sscanf(line, "%d %d %h %d", t, l, d, n) == 4) begin
                    v_test.push_back(t);
                    v_last.push_back(l != 0);
                    v_data.push_back(d);
                    v_len.push_back(n);
                end
            end
            $fclose(fd);
            if (v_test.size() == 0) begin
                $display("vector file holds no vectors");
                tb_errors++;
            end
        end
    endtask

    task automatic start_test(input int num);
        cur_test = num;
        err_mark = tb_errors + chk_errors;
    endtask

    task automatic finish_test();
        int errs;
        errs = tb_errors + chk_errors - err_mark;
        if (errs == 0) begin
            $display("test %0d: passed", cur_test);
            n_pass++;
        end else begin
            $display("test %0d: failed with %0d errors", cur_test, errs);
            n_fail++;
        end
    endtask

    // words back to back, then wait for bursts and capture to drain
    task automatic send_frame(inout int idx);
        int exp_beats;
        int start_beats;
        bit done;
        exp_beats = 0;
        start_beats = beat_total;
        done = 1'b0;
        while (!done && idx < v_test.size()) begin
            @(negedge rxclk);
            sfp_rxdatavalid = 1'b1;
            sfp_rxdatalast = v_last[idx];
            sfp_rxdata = v_data[idx];
            exp_beats += v_len[idx];
            done = v_last[idx];
            idx++;
        end
        @(negedge rxclk);
        sfp_rxdatavalid = 1'b0;
        sfp_rxdatalast = 1'b0;
        sfp_rxdata = '0;
        while (chk_busy) begin
            @(negedge rxclk);
        end
        repeat (6) @(negedge rxclk);
        if (beat_total - start_beats != exp_beats) begin
            $display("ERR %0t: test %0d frame gave %0d output words, expected %0d", $time,
                     cur_test, beat_total - start_beats, exp_beats);
            tb_errors++;
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (load_done);
        limit = v_test.size() * 64 + `LA_PORT_NUM * `LA_SAMPLE_DEPTH + 200;
        repeat (limit) @(posedge rxclk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int idx;
        rstn = 1'b0;
        sfp_rxdatavalid = 1'b0;
        sfp_rxdatalast = 1'b0;
        sfp_rxdata = '0;
        load_vectors();
        load_done = 1'b1;
        repeat (2) @(negedge rxclk);
        rstn = 1'b1;
        // quiet line after reset
        start_test(1);
        repeat (16) @(negedge rxclk);
        finish_test();
        idx = 0;
        while (idx < v_test.size()) begin
            start_test(v_test[idx]);
            while (idx < v_test.size() && v_test[idx] == cur_test) begin
                send_frame(idx);
            end
            finish_test();
        end
        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && tb_errors + chk_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/cmd_pkg.sv
logic/capture_pkg.sv
logic/cmd_decoder.sv
logic/sample_buffer.sv
logic/readout_sequencer.sv
logic/la_rx_top.sv
tb/la_checker.sv
tb/tb_la_rx.sv

// ==== run.sh ====
#!/bin/sh
# build and run the la_rx testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_la_rx -f all.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_la_rx)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== tb/la_vectors.txt ====
# columns: test number, last flag, command word in hex, expected output words
# read request word is 6 reserved bits, num in 10 bits, global addr in 16 bits
2 0 00000000 0
2 0 0000ffff 0
2 1 12345678 0
3 0 ff000000 0
3 1 00080000 8
3 0 ff000000 0
3 1 00050864 5
3 0 ff000000 0
3 1 000817fc 8
4 0 ff000000 0
4 1 00041800 0
4 0 ff000000 0
4 1 00000010 0
4 0 5a000000 0
4 0 0000ffff 0
4 1 00080000 0
4 0 ff000000 0
4 1 00040010 4
5 0 ff000000 0
5 0 00060010 6
5 1 00060810 0
6 0 00000000 0
6 0 0000ffff 0
6 1 00000001 0
6 0 ff000000 0
6 1 000a17d0 10
6 0 ff000000 0
6 1 00030005 3
